//--- tests/cin_stim.txt
# cmd a1 a2 a3, all hex: W adr data | R adr expected | L locked | Q cycles
# S payload_words shift_bits delay_bits
L 0
R 4 00000000
W 2 00000000
R 3 00000000
W 1 00000025
W 2 00000000
R 3 00000025
W 1 00000213
W 2 00000001
R 3 00000013
W 2 00000002
R 3 0000008C
W 2 00000003
R 3 0000008C
W 0 00000001
W 1 00000077
W 2 00000000
R 3 00000025
R 0 00000001
W 0 00000000
W 1 00000000
W 1 00000200
W 0 00000002
S 4 3 0
W 0 00000000
L 0
Q 28
W 1 00000040
W 1 00000220
W 0 00000002
S 3 6 3
W 0 00000000
L 0
Q 18

//--- sources.f
source/surf_cin_pkg.sv
source/cin_lane_frontend.sv
source/cin_word_aligner.sv
source/cin_wb_regs.sv
source/surf_cin_top.sv
tests/surf_cin_sva.sv
tests/tb_surf_cin.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_surf_cin \
    --Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi
if ! grep -q "Test OK" sim.log; then
    echo "simulation ended without a result, see sim.log"
    exit 1
fi
echo "simulation passed"
exit 0

//--- tests/tb_surf_cin.sv
`timescale 1ns/1ps
module tb_surf_cin;
    import surf_cin_pkg::*;

    localparam int TMO = 400;

    logic              rxclk_i;
    logic              reset_i;
    logic              wb_cyc_i;
    logic              wb_stb_i;
    logic              wb_we_i;
    logic [2:0]        wb_adr_i;
    logic [31:0]       wb_dat_i;
    logic [31:0]       wb_dat_o;
    logic              wb_ack_o;
    logic [NIB_W-1:0]  nibble_i;
    cin_word_t         word_o;
    logic              locked_o;

    bit                tx_q[$];
    int                bit_count;
    int                err_word;
    int                err_status;
    int                err_data;
    logic [31:0]       lcg_state;

    surf_cin_top #(
        .INV(1'b1)
    ) u_dut (
        .rxclk_i (rxclk_i),
        .reset_i (reset_i),
        .wb_cyc_i(wb_cyc_i),
        .wb_stb_i(wb_stb_i),
        .wb_we_i (wb_we_i),
        .wb_adr_i(wb_adr_i),
        .wb_dat_i(wb_dat_i),
        .wb_dat_o(wb_dat_o),
        .wb_ack_o(wb_ack_o),
        .nibble_i(nibble_i),
        .word_o  (word_o),
        .locked_o(locked_o)
    );

    initial begin
        rxclk_i = 1'b0;
        forever #2 rxclk_i = ~rxclk_i;
    end

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $finish;
    endtask

    // serial line driven one nibble per cycle and inverted for the lane polarity
    initial begin
        reset_i = 1'b1;
        nibble_i = '1;
        bit_count = 0;
        repeat (16) @(posedge rxclk_i);
        @(negedge rxclk_i);
        reset_i = 1'b0;
        forever begin
            // idle line carries zeros
            for (int j = 0; j < NIB_W; j++) begin
                nibble_i[NIB_W-1-j] = (tx_q.size() > 0) ? ~tx_q.pop_front() : 1'b1;
            end
            bit_count += NIB_W;
            @(negedge rxclk_i);
        end
    end

    task automatic check_word(string name, cin_word_t exp, cin_word_t act);
        if (act !== exp) begin
            err_word++;
            $display("** Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_status(string name, align_status_t exp, align_status_t act);
        if (act !== exp) begin
            err_status++;
            $display("** Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_data(string name, logic [31:0] exp, logic [31:0] act);
        if (act !== exp) begin
            err_data++;
            $display("** Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic wb_cycle(input logic we, input logic [2:0] adr, input logic [31:0] dat,
                            output logic [31:0] rdat);
        int t;
        @(negedge rxclk_i);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = dat;
        t = 0;
        @(negedge rxclk_i);
        while (!wb_ack_o && t < TMO) begin
            @(negedge rxclk_i);
            t++;
        end
        if (!wb_ack_o) begin
            abort_run("no Wishbone ack within the timeout");
        end
        rdat = wb_dat_o;
        // hold through the ack cycle
        @(negedge rxclk_i);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic wait_word(output cin_word_t w);
        int t;
        t = 0;
        @(negedge rxclk_i);
        while (!word_o.valid && t < TMO) begin
            @(negedge rxclk_i);
            t++;
        end
        if (!word_o.valid) begin
            abort_run("no valid word from the aligner within the timeout");
        end
        w = word_o;
    endtask

    task automatic expect_quiet(int cycles);
        repeat (cycles) begin
            @(negedge rxclk_i);
            if (word_o.valid) begin
                err_word++;
                $display("a valid word appeared while the aligner should be idle");
            end
        end
    endtask

    task automatic send_burst(int n, int shift, int dly);
        logic [31:0]   exp_q[$];
        logic [31:0]   rdat;
        cin_word_t     got;
        align_status_t exp_st;
        int            b_last;
        @(posedge rxclk_i);
        // line index of the last training bit
        b_last = bit_count + tx_q.size() + shift + WORD_W - 1;
        repeat (shift) tx_q.push_back(1'b0);
        exp_q.push_back(TRAIN_PATTERN);
        for (int i = 0; i < n; i++) begin
            exp_q.push_back(lcg_next());
        end
        foreach (exp_q[i]) begin
            for (int b = WORD_W - 1; b >= 0; b--) begin
                tx_q.push_back(exp_q[i][b]);
            end
        end
        foreach (exp_q[i]) begin
            wait_word(got);
            check_word($sformatf("burst word %0d", i), cin_word_t'({1'b1, exp_q[i]}), got);
        end
        check_data("locked_o after lock", 32'd1, {31'd0, locked_o});
        // front end register plus the phase step ahead of the compare
        exp_st.locked     = 1'b1;
        exp_st.bit_offset = OFFSET_W'((b_last + dly + NIB_W) % WORD_W);
        exp_st.word_count = COUNT_W'(n);
        wb_cycle(1'b0, REG_STATUS, 32'd0, rdat);
        check_status("status after burst", exp_st, rdat[21:0]);
        wb_cycle(1'b0, REG_LAST_WORD, 32'd0, rdat);
        check_data("last word", exp_q[exp_q.size()-1], rdat);
    endtask

    initial begin
        int          fd;
        int          code;
        int          t;
        string       line;
        string       cmd;
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] a3;
        logic [31:0] rdat;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        err_word = 0;
        err_status = 0;
        err_data = 0;
        lcg_state = 32'hd751_3241;
        t = 0;
        while (reset_i !== 1'b0 && t < 100) begin
            @(posedge rxclk_i);
            t++;
        end
        if (reset_i !== 1'b0) begin
            abort_run("reset never released");
        end
        fd = $fopen("tests/cin_stim.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open tests/cin_stim.txt");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line[0] != "#") begin
                code = $sscanf(line, "%s %h %h %h", cmd, a1, a2, a3);
                case (cmd)
                    "W": wb_cycle(1'b1, a1[2:0], a2, rdat);
                    "R": begin
                        wb_cycle(1'b0, a1[2:0], 32'd0, rdat);
                        check_data($sformatf("read reg %0d", a1), a2, rdat);
                    end
                    "L": begin
                        @(negedge rxclk_i);
                        check_data("locked_o", a1, {31'd0, locked_o});
                    end
                    "Q": expect_quiet(a1);
                    "S": send_burst(a1, a2, a3);
                    default: begin
                        err_data++;
                        $display("unknown command in the stimulus file: %s", cmd);
                    end
                endcase
            end
        end
        $fclose(fd);
        $display("errors: word %0d status %0d data %0d", err_word, err_status, err_data);
        if (err_word + err_status + err_data == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- tests/surf_cin_sva.sv
`timescale 1ns/1ps
module surf_cin_sva (
    input logic                      rxclk_i,
    input logic                      reset_i,
    input logic                      wb_cyc_i,
    input logic                      wb_stb_i,
    input logic                      wb_ack_o,
    input surf_cin_pkg::delay_ctrl_t delay_ctrl_o
);

    // single-cycle ack
    ack_one_cycle: assert property (@(posedge rxclk_i) disable iff (reset_i)
        wb_ack_o |=> !wb_ack_o)
        else $error("ack held for more than one cycle");

    // ack only follows a strobe
    ack_after_stb: assert property (@(posedge rxclk_i) disable iff (reset_i)
        wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
        else $error("ack without a strobe in the previous cycle");

    load_rd_apart: assert property (@(posedge rxclk_i) disable iff (reset_i)
        !(delay_ctrl_o.load && delay_ctrl_o.rd))
        else $error("delay load and read strobes high together");

endmodule

bind cin_wb_regs surf_cin_sva u_sva (
    .rxclk_i     (rxclk_i),
    .reset_i     (reset_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_ack_o    (wb_ack_o),
    .delay_ctrl_o(delay_ctrl_o)
);

//--- source/surf_cin_top.sv
`timescale 1ns/1ps
module surf_cin_top #(
    parameter bit INV = 1'b0
) (
    input  logic                           rxclk_i,
    input  logic                           reset_i,
    input  logic                           wb_cyc_i,
    input  logic                           wb_stb_i,
    input  logic                           wb_we_i,
    input  logic [2:0]                     wb_adr_i,
    input  logic [31:0]                    wb_dat_i,
    output logic [31:0]                    wb_dat_o,
    output logic                           wb_ack_o,
    input  logic [surf_cin_pkg::NIB_W-1:0] nibble_i,
    output surf_cin_pkg::cin_word_t        word_o,
    output logic                           locked_o
);
    import surf_cin_pkg::*;

    delay_ctrl_t      delay_ctrl;
    logic [TAP_W-1:0] delay_value;
    logic [NIB_W-1:0] lane_nibble;
    cin_word_t        word;
    align_status_t    status;
    logic             align_en;

    // polarity and delay model ahead of the aligner
    cin_lane_frontend #(
        .INV(INV)
    ) u_frontend (
        .rxclk_i      (rxclk_i),
        .reset_i      (reset_i),
        .ctrl_i       (delay_ctrl),
        .nibble_i     (nibble_i),
        .nibble_o     (lane_nibble),
        .delay_value_o(delay_value)
    );

    cin_word_aligner u_aligner (
        .rxclk_i   (rxclk_i),
        .reset_i   (reset_i),
        .align_en_i(align_en),
        .nibble_i  (lane_nibble),
        .word_o    (word),
        .status_o  (status)
    );

    cin_wb_regs u_regs (
        .rxclk_i      (rxclk_i),
        .reset_i      (reset_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .delay_value_i(delay_value),
        .word_i       (word),
        .status_i     (status),
        .delay_ctrl_o (delay_ctrl),
        .align_en_o   (align_en)
    );

    assign word_o   = word;
    assign locked_o = status.locked;

endmodule

//--- source/cin_wb_regs.sv
`timescale 1ns/1ps
module cin_wb_regs (
    input  logic                           rxclk_i,
    input  logic                           reset_i,
    input  logic                           wb_cyc_i,
    input  logic                           wb_stb_i,
    input  logic                           wb_we_i,
    input  logic [2:0]                     wb_adr_i,
    input  logic [31:0]                    wb_dat_i,
    output logic [31:0]                    wb_dat_o,
    output logic                           wb_ack_o,
    input  logic [surf_cin_pkg::TAP_W-1:0] delay_value_i,
    input  surf_cin_pkg::cin_word_t        word_i,
    input  surf_cin_pkg::align_status_t    status_i,
    output surf_cin_pkg::delay_ctrl_t      delay_ctrl_o,
    output logic                           align_en_o
);
    import surf_cin_pkg::*;

    logic              ack_q;
    logic [31:0]       dat_q;
    logic [31:0]       rd_mux;
    logic              wr_stb;
    logic [1:0]        ctrl_q;
    logic              load_q;
    logic              rd_q;
    delay_sel_e        sel_q;
    logic [TAP_W-1:0]  cntval_q;
    logic [WORD_W-1:0] last_word_q;

    // write lands at the end of the ack cycle
    assign wr_stb = ack_q && wb_cyc_i && wb_stb_i && wb_we_i;

    always_ff @(posedge rxclk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_cyc_i && wb_stb_i && !ack_q;
        end
    end

    always_comb begin
        case (wb_addr_e'(wb_adr_i))
            REG_CTRL:       rd_mux = {30'd0, ctrl_q};
            REG_DELAY_LOAD: rd_mux = {23'd0, cntval_q};
            REG_DELAY_READ: rd_mux = {30'd0, sel_q};
            REG_DELAY_VAL:  rd_mux = {23'd0, delay_value_i};
            REG_STATUS:     rd_mux = {10'd0, status_i};
            REG_LAST_WORD:  rd_mux = last_word_q;
            default:        rd_mux = '0;
        endcase
    end

    // read data captured as ack rises
    always_ff @(posedge rxclk_i) begin
        if (wb_cyc_i && wb_stb_i && !ack_q) begin
            dat_q <= rd_mux;
        end
    end

    always_ff @(posedge rxclk_i) begin
        if (reset_i) begin
            ctrl_q   <= '0;
            load_q   <= 1'b0;
            rd_q     <= 1'b0;
            sel_q    <= SEL_IDELAY;
            cntval_q <= '0;
        end else begin
            // load and rd are single-cycle strobes
            load_q <= 1'b0;
            rd_q   <= 1'b0;
            if (wr_stb) begin
                case (wb_addr_e'(wb_adr_i))
                    REG_CTRL: begin
                        ctrl_q <= wb_dat_i[1:0];
                    end
                    REG_DELAY_LOAD: begin
                        load_q   <= 1'b1;
                        cntval_q <= wb_dat_i[TAP_W-1:0];
                        sel_q    <= wb_dat_i[9] ? SEL_ODELAY : SEL_IDELAY;
                    end
                    REG_DELAY_READ: begin
                        rd_q  <= 1'b1;
                        sel_q <= delay_sel_e'(wb_dat_i[1:0]);
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge rxclk_i) begin
        if (word_i.valid) begin
            last_word_q <= word_i.data;
        end
    end

    assign wb_ack_o = ack_q;
    assign wb_dat_o = dat_q;

    assign delay_ctrl_o.en_vtc     = ctrl_q[0];
    assign delay_ctrl_o.load       = load_q;
    assign delay_ctrl_o.rd         = rd_q;
    assign delay_ctrl_o.sel        = sel_q;
    assign delay_ctrl_o.cntvaluein = cntval_q;
    assign align_en_o = ctrl_q[1];

endmodule

//--- source/cin_word_aligner.sv
`timescale 1ns/1ps
module cin_word_aligner (
    input  logic                            rxclk_i,
    input  logic                            reset_i,
    input  logic                            align_en_i,
    input  logic [surf_cin_pkg::NIB_W-1:0]  nibble_i,
    output surf_cin_pkg::cin_word_t         word_o,
    output surf_cin_pkg::align_status_t     status_o
);
    import surf_cin_pkg::*;

    localparam int PH_W = OFFSET_W - $clog2(NIB_W);
    localparam int POS_W = $clog2(NIB_W);
    localparam int WIN_W = WORD_W + NIB_W;

    align_state_e        state_q;
    logic [WORD_W-1:0]   window_q;
    logic [WIN_W-1:0]    window;
    logic [PH_W-1:0]     phase_q;
    logic [OFFSET_W-1:0] offset_q;
    logic [COUNT_W-1:0]  count_q;
    logic                valid_q;
    logic [WORD_W-1:0]   data_q;
    logic                hit;
    logic [POS_W-1:0]    hit_pos;
    logic [POS_W-1:0]    take_pos;

    // current nibble joins the stored bits
    assign window = {window_q, nibble_i};

    // candidate c ends at bit c of the new nibble, counted in arrival order
    always_comb begin
        hit = 1'b0;
        hit_pos = '0;
        for (int c = NIB_W - 1; c >= 0; c--) begin
            if (window[(NIB_W - 1 - c) +: WORD_W] == TRAIN_PATTERN) begin
                hit = 1'b1;
                hit_pos = POS_W'(c);
            end
        end
    end

    // lowest index in window where the chosen word ends
    assign take_pos = (state_q == ALIGN_HUNT) ? ~hit_pos : ~offset_q[POS_W-1:0];

    always_ff @(posedge rxclk_i) begin
        window_q <= window[WORD_W-1:0];
        data_q   <= window[take_pos +: WORD_W];
    end

    always_ff @(posedge rxclk_i) begin
        if (reset_i) begin
            state_q  <= ALIGN_HUNT;
            phase_q  <= '0;
            offset_q <= '0;
            count_q  <= '0;
            valid_q  <= 1'b0;
        end else begin
            // nibble phase runs free, 8 nibbles per word
            phase_q <= phase_q + 1'b1;
            valid_q <= 1'b0;
            case (state_q)
                ALIGN_HUNT: begin
                    if (align_en_i && hit) begin
                        state_q  <= ALIGN_LOCKED;
                        offset_q <= {phase_q, hit_pos};
                        count_q  <= '0;
                        valid_q  <= 1'b1;
                    end
                end
                ALIGN_LOCKED: begin
                    if (!align_en_i) begin
                        state_q <= ALIGN_HUNT;
                    end else if (phase_q == offset_q[OFFSET_W-1:POS_W]) begin
                        // words after the training word
                        valid_q <= 1'b1;
                        count_q <= count_q + 1'b1;
                    end
                end
                default: state_q <= ALIGN_HUNT;
            endcase
        end
    end

    assign word_o.valid = valid_q;
    assign word_o.data  = data_q;

    assign status_o.locked     = (state_q == ALIGN_LOCKED);
    assign status_o.bit_offset = offset_q;
    assign status_o.word_count = count_q;

endmodule

//--- source/cin_lane_frontend.sv
`timescale 1ns/1ps
module cin_lane_frontend #(
    parameter bit INV = 1'b0
) (
    input  logic                             rxclk_i,
    input  logic                             reset_i,
    input  surf_cin_pkg::delay_ctrl_t        ctrl_i,
    input  logic [surf_cin_pkg::NIB_W-1:0]   nibble_i,
    output logic [surf_cin_pkg::NIB_W-1:0]   nibble_o,
    output logic [surf_cin_pkg::TAP_W-1:0]   delay_value_o
);
    import surf_cin_pkg::*;

    localparam int DLY_W = $clog2(MAX_BIT_DELAY + 1);
    localparam int STEP_SHIFT = $clog2(TAPS_PER_BIT);
    // oldest bit we may need plus the incoming nibble
    localparam int HIST_W = NIB_W + MAX_BIT_DELAY + 1;

    logic [TAP_W-1:0]        idelay_q;
    logic [TAP_W-1:0]        odelay_q;
    logic [TAP_W-1:0]        value_q;
    logic [TAP_W-1:0]        value_sel;
    logic [TAP_W:0]          tap_sum;
    logic [TAP_W:0]          bit_steps;
    logic [DLY_W-1:0]        bit_delay;
    logic [NIB_W-1:0]        nibble_pol;
    logic [HIST_W-NIB_W-1:0] hist_q;
    logic [HIST_W-1:0]       history;

    // lane polarity
    assign nibble_pol = INV ? ~nibble_i : nibble_i;

    // tap registers, frozen while vtc is enabled
    always_ff @(posedge rxclk_i) begin
        if (reset_i) begin
            idelay_q <= '0;
            odelay_q <= '0;
        end else if (ctrl_i.load && !ctrl_i.en_vtc) begin
            if (ctrl_i.sel[0]) begin
                odelay_q <= ctrl_i.cntvaluein;
            end else begin
                idelay_q <= ctrl_i.cntvaluein;
            end
        end
    end

    always_comb begin
        case (ctrl_i.sel)
            SEL_IDELAY:     value_sel = idelay_q;
            SEL_ODELAY:     value_sel = odelay_q;
            default:        value_sel = MON_TAP_COUNT;
        endcase
    end

    // readback latch
    always_ff @(posedge rxclk_i) begin
        if (reset_i) begin
            value_q <= '0;
        end else if (ctrl_i.rd) begin
            value_q <= value_sel;
        end
    end

    assign delay_value_o = value_q;

    // cascade modeled as whole-bit shift of the stream
    assign tap_sum = {1'b0, idelay_q} + {1'b0, odelay_q};
    assign bit_steps = tap_sum >> STEP_SHIFT;
    assign bit_delay = (bit_steps > MAX_BIT_DELAY) ? DLY_W'(MAX_BIT_DELAY)
                                                   : bit_steps[DLY_W-1:0];

    // newest bits sit at the bottom, first received bit highest
    assign history = {hist_q, nibble_pol};

    always_ff @(posedge rxclk_i) begin
        hist_q   <= history[HIST_W-NIB_W-1:0];
        nibble_o <= history[bit_delay +: NIB_W];
    end

endmodule

//--- source/surf_cin_pkg.sv
package surf_cin_pkg;

    // delay taps and stream widths
    localparam int TAP_W = 9;
    localparam int NIB_W = 4;
    localparam int WORD_W = 32;
    localparam int OFFSET_W = 5;
    localparam int COUNT_W = 16;

    // combined taps per bit of modeled shift
    localparam int TAPS_PER_BIT = 32;
    localparam int MAX_BIT_DELAY = 15;

    // the monitor chain sits at a fixed delay
    localparam logic [TAP_W-1:0] MON_TAP_COUNT = 9'd140;

    localparam logic [WORD_W-1:0] TRAIN_PATTERN = 32'hA55A_3CC3;

    typedef enum logic [1:0] {
        SEL_IDELAY     = 2'd0,
        SEL_ODELAY     = 2'd1,
        SEL_IDELAY_MON = 2'd2,
        SEL_ODELAY_MON = 2'd3
    } delay_sel_e;

    typedef enum logic {
        ALIGN_HUNT   = 1'b0,
        ALIGN_LOCKED = 1'b1
    } align_state_e;

    typedef enum logic [2:0] {
        REG_CTRL       = 3'd0,
        REG_DELAY_LOAD = 3'd1,
        REG_DELAY_READ = 3'd2,
        REG_DELAY_VAL  = 3'd3,
        REG_STATUS     = 3'd4,
        REG_LAST_WORD  = 3'd5
    } wb_addr_e;

    typedef struct packed {
        logic             en_vtc;
        logic             load;
        logic             rd;
        delay_sel_e       sel;
        logic [TAP_W-1:0] cntvaluein;
    } delay_ctrl_t;

    typedef struct packed {
        logic                locked;
        logic [OFFSET_W-1:0] bit_offset;
        logic [COUNT_W-1:0]  word_count;
    } align_status_t;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] data;
    } cin_word_t;

endpackage
